// File: fmul.f
+incdir+include
hw/fmul_pkg.sv
hw/float_unpack.sv
hw/float_multiplier.sv
hw/float_round_pack.sv
hw/fmul_top.sv
testbench/fmul_tb.sv

// File: Makefile
TOP = fmul_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f fmul.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -F "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// File: include/fmul_tb_vectors.svh
`ifndef FMUL_TB_VECTORS_SVH
`define FMUL_TB_VECTORS_SVH

// Columns are a, b, rounding mode, expected y, expected flags {nv, of, uf, nx}
localparam int num_vectors = 36;

localparam vector_t vectors [num_vectors] = '{
	'{32'h3fc00000, 32'h40000000, rne, 32'h40400000, 4'b0000},  // 1.5 * 2.0
	'{32'hc0400000, 32'h3f000000, rne, 32'hbfc00000, 4'b0000},  // -3.0 * 0.5
	'{32'h3fc00000, 32'h3fc00000, rne, 32'h40100000, 4'b0000},  // Product in [2,4)
	// (1 + 2^-23)^2 leaves only sticky bits below the kept mantissa
	'{32'h3f800001, 32'h3f800001, rne, 32'h3f800002, 4'b0001},
	'{32'h3f800001, 32'h3f800001, rtz, 32'h3f800002, 4'b0001},
	'{32'h3f800001, 32'h3f800001, rdn, 32'h3f800002, 4'b0001},
	'{32'h3f800001, 32'h3f800001, rup, 32'h3f800003, 4'b0001},
	'{32'h3f800001, 32'h3f800001, rmm, 32'h3f800002, 4'b0001},
	'{32'hbf800001, 32'h3f800001, rdn, 32'hbf800003, 4'b0001},
	'{32'hbf800001, 32'h3f800001, rup, 32'hbf800002, 4'b0001},
	// Exact ties on an even and on an odd lsb
	'{32'h3f800003, 32'h3fc00000, rne, 32'h3fc00004, 4'b0001},
	'{32'h3f800003, 32'h3fc00000, rmm, 32'h3fc00005, 4'b0001},
	'{32'h3f800001, 32'h3fc00000, rne, 32'h3fc00002, 4'b0001},
	'{32'h3f800001, 32'h3fc00000, rtz, 32'h3fc00001, 4'b0001},
	'{32'h3fffffff, 32'h3fffffff, rne, 32'h407ffffe, 4'b0001},
	'{32'h3fffffff, 32'h3fffffff, rup, 32'h407fffff, 4'b0001},
	'{32'h3f800001, 32'h3ffffffe, rne, 32'h40000000, 4'b0001},  // Rounding carries into exponent
	'{32'h3f800001, 32'h3ffffffe, rtz, 32'h3fffffff, 4'b0001},
	// Special operands
	'{32'h7fc00000, 32'h3f800000, rne, 32'h7fc00000, 4'b0000},
	'{32'h7fc12345, 32'h40000000, rne, 32'h7fc00000, 4'b0000},
	'{32'h7f800001, 32'h3f800000, rne, 32'h7fc00000, 4'b1000},
	'{32'h00000000, 32'h7f800000, rne, 32'h7fc00000, 4'b1000},
	'{32'h7f800000, 32'hc0000000, rne, 32'hff800000, 4'b0000},
	'{32'h80000000, 32'h40a00000, rne, 32'h80000000, 4'b0000},
	'{32'h7f800000, 32'h7f800000, rtz, 32'h7f800000, 4'b0000},
	// 2^127 * 2 overflows
	'{32'h7f000000, 32'h40000000, rne, 32'h7f800000, 4'b0101},
	'{32'h7f000000, 32'h40000000, rtz, 32'h7f7fffff, 4'b0101},
	'{32'h7f000000, 32'h40000000, rdn, 32'h7f7fffff, 4'b0101},
	'{32'hff000000, 32'h40000000, rup, 32'hff7fffff, 4'b0101},
	'{32'hff000000, 32'h40000000, rdn, 32'hff800000, 4'b0101},
	'{32'hff000000, 32'h40000000, rmm, 32'hff800000, 4'b0101},
	// Below the smallest normal
	'{32'h00800000, 32'h3f000000, rne, 32'h00000000, 4'b0011},
	'{32'h80800000, 32'h3f000000, rne, 32'h80000000, 4'b0011},
	'{32'h00800000, 32'h3f800000, rne, 32'h00800000, 4'b0000},
	'{32'h00000001, 32'h3f800000, rne, 32'h00000000, 4'b0000},  // Subnormal input
	'{32'h80400000, 32'h40000000, rne, 32'h80000000, 4'b0000}
};

`endif

// File: testbench/fmul_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fmul_tb import fmul_pkg::*; ();

	typedef struct packed {
		float_t a;
		float_t b;
		round_mode_t rm;
		float_t y;
		logic [3:0] flags;  // nv, of, uf, nx
	} vector_t;

	`include "fmul_tb_vectors.svh"

	logic clk = 1'b0;
	logic reset;
	logic valid_in;
	logic ready_out;
	float_t a;
	float_t b;
	round_mode_t rm;
	logic valid_out;
	logic ready_in;
	float_t y;
	logic nv;
	logic of;
	logic uf;
	logic nx;

	int errors = 0;
	int out_idx = 0;
	logic [31:0] seed = 32'h73d5926d;
	logic holding = 1'b0;
	float_t held_y;
	logic [3:0] held_flags;

	fmul_top DUT (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.ready_out(ready_out),
		.a(a),
		.b(b),
		.rm(rm),
		.valid_out(valid_out),
		.ready_in(ready_in),
		.y(y),
		.nv(nv),
		.of(of),
		.uf(uf),
		.nx(nx)
	);

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else begin
			errors++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	always #4 clk = ~clk;

	// Consumer is ready about three cycles in four
	always @(negedge clk) begin
		seed = next_random(seed);
		ready_in = seed[31:30] != 2'b00;
	end

	always @(posedge clk) begin
		if (!reset) begin
			if (holding) begin
				assert (valid_out && y === held_y && {nv, of, uf, nx} === held_flags) else begin
					errors++;
					$display("%0t: output changed while the consumer was not ready", $time);
				end
			end
			if (valid_out && ready_in) begin
				if (out_idx < num_vectors) begin
					compare_value("y", y, vectors[out_idx].y);
					compare_value("nv", nv, vectors[out_idx].flags[3]);
					compare_value("of", of, vectors[out_idx].flags[2]);
					compare_value("uf", uf, vectors[out_idx].flags[1]);
					compare_value("nx", nx, vectors[out_idx].flags[0]);
				end else begin
					errors++;
					$display("%0t: a result came out that was never sent in", $time);
				end
				out_idx++;
			end
			holding = valid_out && !ready_in;
			held_y = y;
			held_flags = {nv, of, uf, nx};
		end
	end

	initial begin
		reset = 1'b1;
		valid_in = 1'b0;
		a = 32'd0;
		b = 32'd0;
		rm = rne;
		ready_in = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		compare_value("valid_out", valid_out, 0);
		compare_value("ready_out", ready_out, 1);
		compare_value("nv", nv, 0);
		compare_value("of", of, 0);
		compare_value("uf", uf, 0);
		compare_value("nx", nx, 0);

		for (int i = 0; i < num_vectors; i++) begin
			valid_in = 1'b1;
			a = vectors[i].a;
			b = vectors[i].b;
			rm = vectors[i].rm;
			@(posedge clk);
			while (!ready_out)
				@(posedge clk);
			@(negedge clk);
		end
		valid_in = 1'b0;

		wait (out_idx >= num_vectors);
		repeat (20) @(negedge clk);  // Catch any extra result

		$display("Results %0d of %0d, errors %0d", out_idx, num_vectors, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial begin
		repeat (8 + 40 * num_vectors) @(posedge clk);
		$display("Timeout: only %0d of %0d results arrived", out_idx, num_vectors);
		$display("Results %0d of %0d, errors %0d", out_idx, num_vectors, errors);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/fmul_top.sv
`timescale 1ns/1ps
`default_nettype none

module fmul_top import fmul_pkg::*; (
	input logic clk,
	input logic reset,

	input logic valid_in,
	output logic ready_out,
	input float_t a,
	input float_t b,
	input round_mode_t rm,

	output logic valid_out,
	input logic ready_in,
	output float_t y,
	output logic nv,
	output logic of,
	output logic uf,
	output logic nx
);

	logic unp_valid;
	logic unp_ready;
	mul_req_t req;
	logic mul_valid;
	logic mul_ready;
	mul_res_t res;

	float_unpack u_unpack (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.ready_out(ready_out),
		.a(a),
		.b(b),
		.rm(rm),
		.valid_out(unp_valid),
		.ready_in(unp_ready),
		.req(req)
	);

	float_multiplier u_mul (
		.clk(clk),
		.reset(reset),
		.valid_in(unp_valid),
		.ready_out(unp_ready),
		.req(req),
		.valid_out(mul_valid),
		.ready_in(mul_ready),
		.res(res)
	);

	float_round_pack u_round (
		.clk(clk),
		.reset(reset),
		.valid_in(mul_valid),
		.ready_out(mul_ready),
		.res(res),
		.valid_out(valid_out),
		.ready_in(ready_in),
		.y(y),
		.nv(nv),
		.of(of),
		.uf(uf),
		.nx(nx)
	);

endmodule

`default_nettype wire

// File: hw/float_round_pack.sv
`timescale 1ns/1ps
`default_nettype none

module float_round_pack import fmul_pkg::*; (
	input logic clk,
	input logic reset,

	input logic valid_in,
	output logic ready_out,
	input mul_res_t res,

	output logic valid_out,
	input logic ready_in,
	output float_t y,
	output logic nv,
	output logic of,
	output logic uf,
	output logic nx
);

	logic inexact;
	logic inc;
	logic [24:0] man_sum;
	man_t man_rnd;
	exp_t exp_rnd;
	exp_t biased;
	logic to_max;
	float_t y_next;
	logic of_next;
	logic uf_next;
	logic nx_next;

	assign ready_out = !valid_out || ready_in;
	assign inexact = res.round_bit || res.sticky_bit;

	always_comb begin
		case (res.rm)
			rne: inc = res.round_bit && (res.sticky_bit || res.man[0]);
			rtz: inc = 1'b0;
			rdn: inc = inexact && res.sgn;
			rup: inc = inexact && !res.sgn;
			rmm: inc = res.round_bit;
			default: inc = 1'b0;
		endcase

		man_sum = {1'b0, res.man} + 25'(inc);
		if (man_sum[24]) begin
			man_rnd = man_sum[24:1];
			exp_rnd = res.exp + exp_t'(1);
		end else begin
			man_rnd = man_sum[23:0];
			exp_rnd = res.exp;
		end

		// Modes that never round away from zero stop at the largest finite value
		to_max = (res.rm == rtz) || (res.rm == rdn && !res.sgn) || (res.rm == rup && res.sgn);

		of_next = 1'b0;
		uf_next = 1'b0;
		nx_next = 1'b0;
		if (res.skip_round) begin
			biased = res.exp + exp_t'(float_bias);
			y_next = {res.sgn, biased[7:0], res.man[22:0]};
		end else if (exp_rnd > exp_max) begin
			biased = exp_rnd + exp_t'(float_bias);
			y_next = to_max ? {res.sgn, 8'hfe, 23'h7fffff} : {res.sgn, 8'hff, 23'h000000};
			of_next = 1'b1;
			nx_next = 1'b1;
		end else if (exp_rnd < exp_min) begin
			biased = exp_rnd + exp_t'(float_bias);
			y_next = {res.sgn, 31'd0};  // Flush to signed zero
			uf_next = 1'b1;
			nx_next = 1'b1;
		end else begin
			biased = exp_rnd + exp_t'(float_bias);
			y_next = {res.sgn, biased[7:0], man_rnd[22:0]};
			nx_next = inexact;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_out <= 1'b0;
			y <= 32'd0;
			nv <= 1'b0;
			of <= 1'b0;
			uf <= 1'b0;
			nx <= 1'b0;
		end else begin
			if (ready_out)
				valid_out <= valid_in;
			if (valid_in && ready_out) begin
				y <= y_next;
				nv <= res.iv;
				of <= of_next;
				uf <= uf_next;
				nx <= nx_next;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/float_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module float_multiplier import fmul_pkg::*; (
	input logic clk,
	input logic reset,

	input logic valid_in,
	output logic ready_out,
	input mul_req_t req,

	output logic valid_out,
	input logic ready_in,
	output mul_res_t res
);

	typedef enum logic {
		idle,
		calc
	} state_t;

	state_t state;
	logic [1:0] count;
	man_t man_b;
	logic [47:0] prod;  // Upper half accumulates, lower half shifts out multiplier bits
	exp_t exp_r;
	logic sgn_r;
	logic skip_r;
	logic iv_r;
	round_mode_t rm_r;
	logic [29:0] acc;
	logic is_nan;
	logic is_inf;
	logic is_zero;

	assign ready_out = (state == idle) && (!valid_out || ready_in);

	assign is_nan = req.a.snan || req.b.snan || req.a.qnan || req.b.qnan ||
		(req.a.zero && req.b.inf) || (req.a.inf && req.b.zero);
	assign is_inf = req.a.inf || req.b.inf;
	assign is_zero = req.a.zero || req.b.zero;

	// Six partial products per cycle on top of the running sum
	always_comb begin
		acc = {6'd0, prod[47:24]};
		for (int i = 0; i < 6; i++) begin
			if (prod[i])
				acc = acc + ({6'd0, man_b} << i);
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= idle;
			count <= 2'd0;
			valid_out <= 1'b0;
		end else if (valid_in && ready_out) begin
			count <= 2'd0;
			if (is_nan || is_inf || is_zero) begin
				valid_out <= 1'b1;  // Special cases finish at once
				state <= idle;
			end else begin
				valid_out <= 1'b0;
				state <= calc;
			end
		end else if (state == calc) begin
			count <= count + 2'd1;
			if (count == 2'd3) begin
				valid_out <= 1'b1;
				state <= idle;
			end
		end else if (valid_out && ready_in) begin
			valid_out <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_in && ready_out) begin
			man_b <= req.b.man;
			prod <= {24'd0, req.a.man};
			exp_r <= req.a.exp + req.b.exp;
			sgn_r <= req.a.sgn ^ req.b.sgn;
			skip_r <= 1'b0;
			iv_r <= 1'b0;
			rm_r <= req.rm;
			if (is_nan) begin
				prod <= {1'b1, qnan_value[22:0], 24'd0};
				exp_r <= exp_t'({2'b00, qnan_value[30:23]}) - exp_t'(float_bias);
				sgn_r <= qnan_value[31];
				skip_r <= 1'b1;
				iv_r <= !(req.a.qnan || req.b.qnan);
			end else if (is_inf) begin
				prod <= {1'b1, 47'd0};
				exp_r <= exp_max + exp_t'(1);
				skip_r <= 1'b1;
			end else if (is_zero) begin
				prod <= 48'd0;
				exp_r <= exp_min - exp_t'(1);  // Packs to a zero exponent field
				skip_r <= 1'b1;
			end
		end else if (state == calc) begin
			prod <= {acc, prod[23:6]};
		end
	end

	always_comb begin
		res.sgn = sgn_r;
		res.skip_round = skip_r;
		res.iv = iv_r;
		res.rm = rm_r;
		if (skip_r) begin
			res.man = prod[47:24];
			res.exp = exp_r;
			res.round_bit = 1'b0;
			res.sticky_bit = 1'b0;
		end else if (prod[47]) begin
			// Product in [2,4) so move the point one place
			res.man = prod[47:24];
			res.exp = exp_r + exp_t'(1);
			res.round_bit = prod[23];
			res.sticky_bit = |prod[22:0];
		end else begin
			res.man = prod[46:23];
			res.exp = exp_r;
			res.round_bit = prod[22];
			res.sticky_bit = |prod[21:0];
		end
	end

endmodule

`default_nettype wire

// File: hw/float_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module float_unpack import fmul_pkg::*; (
	input logic clk,
	input logic reset,

	input logic valid_in,
	output logic ready_out,
	input float_t a,
	input float_t b,
	input round_mode_t rm,

	output logic valid_out,
	input logic ready_in,
	output mul_req_t req
);

	function automatic operand_t unpack(input float_t f);
		operand_t op;
		logic [7:0] e;
		logic [22:0] frac;
		e = f[30:23];
		frac = f[22:0];
		op.sgn = f[31];
		op.exp = exp_t'({2'b00, e}) - exp_t'(float_bias);
		op.man = {e != 8'h00, frac};
		// Subnormals count as zero
		op.zero = e == 8'h00;
		op.inf = (e == 8'hff) && (frac == 23'd0);
		op.snan = (e == 8'hff) && (frac != 23'd0) && !frac[22];
		op.qnan = (e == 8'hff) && frac[22];
		return op;
	endfunction

	assign ready_out = !valid_out || ready_in;  // Empty, or drained this cycle

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else if (ready_out) begin
			valid_out <= valid_in;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_in && ready_out) begin
			req.a <= unpack(a);
			req.b <= unpack(b);
			req.rm <= rm;
		end
	end

endmodule

`default_nettype wire

// File: hw/fmul_pkg.sv
`default_nettype none

package fmul_pkg;

	typedef logic [31:0] float_t;
	typedef logic [23:0] man_t;
	typedef logic signed [9:0] exp_t;  // Room for the sum of two exponents plus carries

	typedef enum logic [2:0] {
		rne = 3'd0,
		rtz = 3'd1,
		rdn = 3'd2,
		rup = 3'd3,
		rmm = 3'd4
	} round_mode_t;

	typedef struct packed {
		man_t man;
		exp_t exp;
		logic sgn;
		logic zero;
		logic inf;
		logic snan;
		logic qnan;
	} operand_t;

	typedef struct packed {
		operand_t a;
		operand_t b;
		round_mode_t rm;
	} mul_req_t;

	typedef struct packed {
		man_t man;
		exp_t exp;
		logic sgn;
		logic round_bit;
		logic sticky_bit;
		logic skip_round;  // Special result, already exact
		logic iv;
		round_mode_t rm;
	} mul_res_t;

	localparam int float_bias = 127;
	localparam exp_t exp_max = 127;
	localparam exp_t exp_min = -126;
	localparam float_t qnan_value = 32'h7fc00000;

endpackage

`default_nettype wire
